// ==== hw/vreg_pkg.sv ====
`default_nettype none

package vreg_pkg;

    // vram geometry
    localparam int VRAM_AW = 10;                    // 1024 words
    localparam int REG_W   = 16;                    // register and vram word width

    // host bus pin levels
    localparam logic CS_ENABLED = 1'b0;             // cs_n low selects the block
    localparam logic RNW_READ   = 1'b1;             // rd_nwr high is a read

    // host register numbers
    localparam logic [3:0] REG_VRAM_ADDR  = 4'h0;   // vram access address
    localparam logic [3:0] REG_VRAM_DATA  = 4'h1;   // vram data port, auto increment
    localparam logic [3:0] REG_VRAM_INCR  = 4'h2;   // added to address per data access
    localparam logic [3:0] REG_FILL_COUNT = 4'h3;   // write starts fill, read gives remaining
    localparam logic [3:0] REG_FILL_ADDR  = 4'h4;   // fill start address
    localparam logic [3:0] REG_FILL_DATA  = 4'h5;   // fill word

endpackage

`default_nettype wire

// ==== hw/vram.sv ====
`default_nettype none
`timescale 1ns/1ps

module vram import vreg_pkg::*; (
    input  logic               clk,
    input  logic               en_i,
    input  logic               we_i,
    input  logic [VRAM_AW-1:0] addr_i,
    input  logic [REG_W-1:0]   wdata_i,
    output logic [REG_W-1:0]   rdata_o      // registered, valid cycle after en
);

    logic [REG_W-1:0] mem [2**VRAM_AW];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end
            rdata_o <= mem[addr_i];         // read before write
        end
    end

endmodule

`default_nettype wire

// ==== hw/vram_arbiter.sv ====
`default_nettype none
`timescale 1ns/1ps

module vram_arbiter import vreg_pkg::*; (
    input  logic               clk,
    input  logic               reset_i,
    // register block, higher priority
    input  logic               regs_req_i,
    input  logic               regs_we_i,
    input  logic [VRAM_AW-1:0] regs_addr_i,
    input  logic [REG_W-1:0]   regs_wdata_i,
    output logic               regs_grant_o,
    output logic               regs_rvalid_o,     // read data valid a cycle after grant
    output logic [REG_W-1:0]   regs_rdata_o,
    // fill engine, write only
    input  logic               fill_req_i,
    input  logic [VRAM_AW-1:0] fill_addr_i,
    input  logic [REG_W-1:0]   fill_wdata_i,
    output logic               fill_grant_o,
    // memory port
    output logic               mem_en_o,
    output logic               mem_we_o,
    output logic [VRAM_AW-1:0] mem_addr_o,
    output logic [REG_W-1:0]   mem_wdata_o,
    input  logic [REG_W-1:0]   mem_rdata_i
);

    logic regs_rd_q;                              // granted regs read last cycle

    assign regs_grant_o  = regs_req_i;
    assign fill_grant_o  = fill_req_i && !regs_req_i;   // fill waits behind host
    assign mem_en_o      = regs_req_i || fill_req_i;
    assign mem_we_o      = regs_req_i ? regs_we_i : fill_req_i;
    assign mem_addr_o    = regs_req_i ? regs_addr_i : fill_addr_i;
    assign mem_wdata_o   = regs_req_i ? regs_wdata_i : fill_wdata_i;
    assign regs_rvalid_o = regs_rd_q;
    assign regs_rdata_o  = mem_rdata_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            regs_rd_q <= 1'b0;
        end else begin
            regs_rd_q <= regs_req_i && !regs_we_i;
        end
    end

    // a fill request held back by the host stays up until granted
    a_fill_held: assert property (@(posedge clk) disable iff (reset_i)
        (fill_req_i && !fill_grant_o) |=> fill_req_i)
        else $error("fill request dropped before grant");

endmodule

`default_nettype wire

// ==== hw/vram_fill.sv ====
`default_nettype none
`timescale 1ns/1ps

module vram_fill import vreg_pkg::*; (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               fill_start_i,       // load setup and begin
    input  logic [VRAM_AW-1:0] fill_addr_i,
    input  logic [REG_W-1:0]   fill_data_i,
    input  logic [REG_W-1:0]   fill_count_i,
    output logic [REG_W-1:0]   fill_remaining_o,   // words left to write
    output logic               req_o,
    output logic [VRAM_AW-1:0] addr_o,
    output logic [REG_W-1:0]   wdata_o,
    input  logic               grant_i
);

    logic [VRAM_AW-1:0] addr;          // next address, wraps at vram end
    logic [REG_W-1:0]   count;         // down-counter, busy while nonzero
    logic [REG_W-1:0]   data;

    assign req_o            = (count != '0);
    assign addr_o           = addr;
    assign wdata_o          = data;
    assign fill_remaining_o = count;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            addr  <= '0;
            count <= '0;
        end else if (fill_start_i) begin
            addr  <= fill_addr_i;      // restart even when busy
            count <= fill_count_i;
        end else if (grant_i) begin
            addr  <= addr + 1'b1;
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_start_i) begin
            data <= fill_data_i;
        end
    end

    // arbiter must only grant a live request
    a_grant_has_req: assert property (@(posedge clk) disable iff (reset_i)
        grant_i |-> req_o)
        else $error("fill grant without request");

endmodule

`default_nettype wire

// ==== hw/vram_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module vram_regs import vreg_pkg::*; (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               write_strobe_i,
    input  logic               read_strobe_i,
    input  logic [3:0]         reg_num_i,        // register of the strobe
    input  logic [3:0]         sync_reg_num_i,   // register being read on the bus
    input  logic [REG_W-1:0]   reg_data_i,       // host write word
    output logic [REG_W-1:0]   reg_data_o,       // host read word
    output logic               vram_req_o,
    output logic               vram_we_o,
    output logic [VRAM_AW-1:0] vram_addr_o,
    output logic [REG_W-1:0]   vram_wdata_o,
    input  logic               vram_grant_i,
    input  logic               vram_rvalid_i,
    input  logic [REG_W-1:0]   vram_rdata_i,
    output logic               fill_start_o,
    output logic [VRAM_AW-1:0] fill_addr_o,
    output logic [REG_W-1:0]   fill_data_o,
    output logic [REG_W-1:0]   fill_count_o,
    input  logic [REG_W-1:0]   fill_remaining_i
);

    logic [REG_W-1:0] addr;            // full word kept, low bits reach vram
    logic [REG_W-1:0] incr;
    logic [REG_W-1:0] rd_latch;        // read-ahead word at addr
    logic [REG_W-1:0] fill_addr;
    logic [REG_W-1:0] fill_data;
    logic [REG_W-1:0] fill_count;
    logic             pend;            // request waiting for grant
    logic             pend_we;
    logic [REG_W-1:0] wdata;

    assign vram_req_o   = pend;
    assign vram_we_o    = pend_we;
    assign vram_addr_o  = addr[VRAM_AW-1:0];
    assign vram_wdata_o = wdata;
    assign fill_addr_o  = fill_addr[VRAM_AW-1:0];
    assign fill_data_o  = fill_data;
    assign fill_count_o = fill_count;

    always_comb begin
        case (sync_reg_num_i)
            REG_VRAM_ADDR:  reg_data_o = addr;
            REG_VRAM_DATA:  reg_data_o = rd_latch;
            REG_VRAM_INCR:  reg_data_o = incr;
            REG_FILL_COUNT: reg_data_o = fill_remaining_i;   // live count from fill engine
            REG_FILL_ADDR:  reg_data_o = fill_addr;
            REG_FILL_DATA:  reg_data_o = fill_data;
            default:        reg_data_o = '0;                 // unused registers
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            addr         <= '0;
            incr         <= '0;
            rd_latch     <= '0;
            fill_addr    <= '0;
            fill_data    <= '0;
            fill_count   <= '0;
            fill_start_o <= 1'b0;
            pend         <= 1'b0;
            pend_we      <= 1'b0;
        end else begin
            fill_start_o <= 1'b0;
            if (vram_grant_i) begin
                pend <= 1'b0;
                if (pend_we) begin
                    addr <= addr + incr;            // step after a data write
                end
            end
            if (vram_rvalid_i) begin
                rd_latch <= vram_rdata_i;
            end
            if (write_strobe_i) begin
                case (reg_num_i)
                    REG_VRAM_ADDR: begin
                        addr    <= reg_data_i;
                        pend    <= 1'b1;            // prefetch new address
                        pend_we <= 1'b0;
                    end
                    REG_VRAM_DATA: begin
                        pend    <= 1'b1;
                        pend_we <= 1'b1;
                    end
                    REG_VRAM_INCR:  incr <= reg_data_i;
                    REG_FILL_COUNT: begin
                        fill_count   <= reg_data_i;
                        fill_start_o <= 1'b1;       // kick fill engine
                    end
                    REG_FILL_ADDR:  fill_addr <= reg_data_i;
                    REG_FILL_DATA:  fill_data <= reg_data_i;
                    default: ;
                endcase
            end
            if (read_strobe_i && (reg_num_i == REG_VRAM_DATA)) begin
                addr    <= addr + incr;             // advance, then read ahead
                pend    <= 1'b1;
                pend_we <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_strobe_i && (reg_num_i == REG_VRAM_DATA)) begin
            wdata <= reg_data_i;
        end
    end

    // priority grant must clear a request before the next host word
    a_no_strobe_pending: assert property (@(posedge clk) disable iff (reset_i)
        pend |-> !(write_strobe_i || read_strobe_i))
        else $error("host strobe while vram request pending");

endmodule

`default_nettype wire

// ==== hw/bus_interface.sv ====
`default_nettype none
`timescale 1ns/1ps

module bus_interface import vreg_pkg::*; (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             bus_cs_n_i,        // register select, active low
    input  logic             bus_rd_nwr_i,      // read when high
    input  logic [3:0]       bus_reg_num_i,     // register number
    input  logic             bus_bytesel_i,     // 0 even (high half), 1 odd (low half)
    input  logic [7:0]       bus_data_i,
    output logic [7:0]       bus_data_o,
    output logic             write_strobe_o,    // pulse on odd byte of a write
    output logic             read_strobe_o,     // pulse on odd byte of a read
    output logic [3:0]       reg_num_o,         // register number with the strobes
    output logic [3:0]       sync_reg_num_o,    // selects the read word in vram_regs
    output logic [REG_W-1:0] reg_data_o,        // assembled write word
    input  logic [REG_W-1:0] reg_data_i         // read word for sync_reg_num_o
);

    // synchronizers shift right, msb takes the pin, bit 0 is the synced value
    logic [2:0]      sel_r;                     // extra bit keeps previous select
    logic [1:0]      read_r;
    logic [1:0]      bytesel_r;
    logic [1:0][3:0] reg_num_r;
    logic [1:0][7:0] data_r;

    logic            sel_rise;                  // first cycle of a synced select
    logic            rd;
    logic            bytesel;
    logic [3:0]      reg_num;
    logic [7:0]      data;
    logic            even_wr;                   // even byte of a write seen

    logic [3:0]      even_reg;                  // register that owns the buffered byte
    logic [7:0]      even_data;                 // buffered even byte

    assign sel_rise       = (sel_r[1:0] == 2'b10);
    assign rd             = read_r[0];
    assign bytesel        = bytesel_r[0];
    assign reg_num        = reg_num_r[0];
    assign data           = data_r[0];
    assign even_wr        = sel_rise && !rd && !bytesel;
    assign sync_reg_num_o = reg_num;

    // high half on even byte, low half on odd byte
    assign bus_data_o = bytesel ? reg_data_i[7:0] : reg_data_i[15:8];

    always_ff @(posedge clk) begin
        read_r     <= {(bus_rd_nwr_i == RNW_READ), read_r[1]};
        bytesel_r  <= {bus_bytesel_i, bytesel_r[1]};
        reg_num_r  <= {bus_reg_num_i, reg_num_r[1]};
        data_r     <= {bus_data_i, data_r[1]};
        // high half only when the even byte went to the same register
        reg_data_o <= (reg_num == even_reg) ? {even_data, data} : {8'h00, data};
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sel_r          <= 3'b000;
            write_strobe_o <= 1'b0;
            read_strobe_o  <= 1'b0;
            reg_num_o      <= 4'h0;
            even_reg       <= 4'h0;
            even_data      <= 8'h00;
        end else begin
            sel_r          <= {(bus_cs_n_i == CS_ENABLED), sel_r[2:1]};
            reg_num_o      <= reg_num;
            write_strobe_o <= sel_rise && !rd && bytesel;   // word complete
            read_strobe_o  <= sel_rise && rd && bytesel;    // once per word read
            if (even_wr) begin
                even_reg  <= reg_num;           // remember owner of even byte
                even_data <= data;
            end
        end
    end

    // host keeps register, direction and byte select steady while selected
    a_pins_steady: assert property (@(posedge clk) disable iff (reset_i)
        (sel_r[1] && sel_r[0]) |-> ($stable(reg_num) && $stable(rd) && $stable(bytesel)))
        else $error("bus pins changed while selected");

endmodule

`default_nettype wire

// ==== hw/vreg_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module vreg_top import vreg_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       bus_cs_n_i,
    input  logic       bus_rd_nwr_i,
    input  logic [3:0] bus_reg_num_i,
    input  logic       bus_bytesel_i,
    input  logic [7:0] bus_data_i,
    output logic [7:0] bus_data_o
);

    // host side
    logic               write_strobe;
    logic               read_strobe;
    logic [3:0]         reg_num;
    logic [3:0]         sync_reg_num;
    logic [REG_W-1:0]   host_wr_word;
    logic [REG_W-1:0]   host_rd_word;
    // fill setup
    logic               fill_start;
    logic [VRAM_AW-1:0] fill_addr;
    logic [REG_W-1:0]   fill_data;
    logic [REG_W-1:0]   fill_count;
    logic [REG_W-1:0]   fill_remaining;
    // regs port
    logic               regs_req;
    logic               regs_we;
    logic [VRAM_AW-1:0] regs_addr;
    logic [REG_W-1:0]   regs_wdata;
    logic               regs_grant;
    logic               regs_rvalid;
    logic [REG_W-1:0]   regs_rdata;
    // fill port
    logic               fill_req;
    logic [VRAM_AW-1:0] fill_req_addr;
    logic [REG_W-1:0]   fill_wdata;
    logic               fill_grant;
    // memory
    logic               mem_en;
    logic               mem_we;
    logic [VRAM_AW-1:0] mem_addr;
    logic [REG_W-1:0]   mem_wdata;
    logic [REG_W-1:0]   mem_rdata;

    bus_interface u_bus (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_cs_n_i     (bus_cs_n_i),
        .bus_rd_nwr_i   (bus_rd_nwr_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_data_i     (bus_data_i),
        .bus_data_o     (bus_data_o),
        .write_strobe_o (write_strobe),
        .read_strobe_o  (read_strobe),
        .reg_num_o      (reg_num),
        .sync_reg_num_o (sync_reg_num),
        .reg_data_o     (host_wr_word),
        .reg_data_i     (host_rd_word)
    );

    vram_regs u_regs (
        .clk              (clk),
        .reset_i          (reset_i),
        .write_strobe_i   (write_strobe),
        .read_strobe_i    (read_strobe),
        .reg_num_i        (reg_num),
        .sync_reg_num_i   (sync_reg_num),
        .reg_data_i       (host_wr_word),
        .reg_data_o       (host_rd_word),
        .vram_req_o       (regs_req),
        .vram_we_o        (regs_we),
        .vram_addr_o      (regs_addr),
        .vram_wdata_o     (regs_wdata),
        .vram_grant_i     (regs_grant),
        .vram_rvalid_i    (regs_rvalid),
        .vram_rdata_i     (regs_rdata),
        .fill_start_o     (fill_start),
        .fill_addr_o      (fill_addr),
        .fill_data_o      (fill_data),
        .fill_count_o     (fill_count),
        .fill_remaining_i (fill_remaining)
    );

    vram_fill u_fill (
        .clk              (clk),
        .reset_i          (reset_i),
        .fill_start_i     (fill_start),
        .fill_addr_i      (fill_addr),
        .fill_data_i      (fill_data),
        .fill_count_i     (fill_count),
        .fill_remaining_o (fill_remaining),
        .req_o            (fill_req),
        .addr_o           (fill_req_addr),
        .wdata_o          (fill_wdata),
        .grant_i          (fill_grant)
    );

    vram_arbiter u_arb (
        .clk           (clk),
        .reset_i       (reset_i),
        .regs_req_i    (regs_req),
        .regs_we_i     (regs_we),
        .regs_addr_i   (regs_addr),
        .regs_wdata_i  (regs_wdata),
        .regs_grant_o  (regs_grant),
        .regs_rvalid_o (regs_rvalid),
        .regs_rdata_o  (regs_rdata),
        .fill_req_i    (fill_req),
        .fill_addr_i   (fill_req_addr),
        .fill_wdata_i  (fill_wdata),
        .fill_grant_o  (fill_grant),
        .mem_en_o      (mem_en),
        .mem_we_o      (mem_we),
        .mem_addr_o    (mem_addr),
        .mem_wdata_o   (mem_wdata),
        .mem_rdata_i   (mem_rdata)
    );

    vram u_vram (
        .clk     (clk),
        .en_i    (mem_en),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== test/vreg_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

module vreg_checker (
    input  logic       clk,
    input  logic [7:0] bus_data_i,      // dut read byte
    input  logic       sample_i,        // capture at this negedge
    input  logic       compare_i,       // compare with exp_i, else capture only
    input  logic [7:0] exp_i,
    input  logic       fault_i,         // non-value failure seen by the testbench
    input  logic       test_done_i,     // close the current test
    input  logic [3:0] test_num_i,
    output logic [7:0] sampled_o,       // last captured byte, used for polling
    output int         check_count_o,
    output int         error_count_o
);

    logic [7:0] sampled = 8'h00;
    int         checks = 0;
    int         errors = 0;
    int         test_checks = 0;        // per test, cleared on test_done_i
    int         test_errors = 0;

    assign sampled_o     = sampled;
    assign check_count_o = checks;
    assign error_count_o = errors;

    // negedge sits mid cycle, pins and bus_data_o are settled here
    always @(negedge clk) begin
        if (sample_i) begin
            sampled = bus_data_i;
            if (compare_i) begin
                checks++;
                test_checks++;
                if (bus_data_i !== exp_i) begin
                    errors++;
                    test_errors++;
                    $display("MISMATCH at %0t ns: test %0d read 0x%02h, expected 0x%02h",
                             $time, test_num_i, bus_data_i, exp_i);
                end
            end
        end
        if (fault_i) begin
            errors++;
            test_errors++;
        end
        if (test_done_i) begin
            $display("test %0d finished: %0d byte checks, %0d errors",
                     test_num_i, test_checks, test_errors);
            test_checks = 0;
            test_errors = 0;
        end
    end

endmodule

`default_nettype wire

// ==== test/vreg_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module vreg_tb import vreg_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int POLL_LIMIT   = 64;           // FILL_COUNT reads before giving up
    localparam int FILL1_LEN    = 40;
    localparam int FILL2_LEN    = 200;          // long enough to overlap host writes
    localparam logic [REG_W-1:0] FILL1_BASE = 16'h0100;
    localparam logic [REG_W-1:0] FILL2_BASE = 16'h0200;
    localparam logic [REG_W-1:0] HOST_BASE  = 16'h0300;   // disjoint from fill 2

    localparam logic [2:0] OP_WR      = 3'd0;   // full word, even byte first
    localparam logic [2:0] OP_RD      = 3'd1;
    localparam logic [2:0] OP_WR_EVEN = 3'd2;   // even byte only, no strobe
    localparam logic [2:0] OP_WR_ODD  = 3'd3;   // odd byte only
    localparam logic [2:0] OP_POLL    = 3'd4;   // read until the word matches

    typedef struct packed {
        logic [2:0]       op;
        logic [3:0]       test;
        logic [3:0]       reg_num;
        logic [REG_W-1:0] word;                 // write word
        logic [REG_W-1:0] exp_word;             // expected read word
    } row_t;

    logic       clk;
    logic       reset_i;
    logic       bus_cs_n;
    logic       bus_rd_nwr;
    logic [3:0] bus_reg_num;
    logic       bus_bytesel;
    logic [7:0] bus_data_in;
    logic [7:0] bus_data_out;

    logic       sample_req;
    logic       sample_cmp;
    logic [7:0] sample_exp;
    logic [7:0] sampled;
    logic       fault;
    logic       test_done;
    logic [3:0] test_num;
    int         check_count;
    int         error_count;

    row_t       rows[$];
    logic [3:0] table_test;                     // test number for new rows
    int         timeout_limit = 0;
    int         cycles = 0;

    vreg_top uut (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n),
        .bus_rd_nwr_i  (bus_rd_nwr),
        .bus_reg_num_i (bus_reg_num),
        .bus_bytesel_i (bus_bytesel),
        .bus_data_i    (bus_data_in),
        .bus_data_o    (bus_data_out)
    );

    vreg_checker chk (
        .clk           (clk),
        .bus_data_i    (bus_data_out),
        .sample_i      (sample_req),
        .compare_i     (sample_cmp),
        .exp_i         (sample_exp),
        .fault_i       (fault),
        .test_done_i   (test_done),
        .test_num_i    (test_num),
        .sampled_o     (sampled),
        .check_count_o (check_count),
        .error_count_o (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (timeout_limit > 0 && cycles >= timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic void add_row(input logic [2:0] op, input logic [3:0] reg_num,
                                    input logic [REG_W-1:0] word,
                                    input logic [REG_W-1:0] exp_word);
        row_t r;
        r.op       = op;
        r.test     = table_test;
        r.reg_num  = reg_num;
        r.word     = word;
        r.exp_word = exp_word;
        rows.push_back(r);
    endfunction

    function automatic logic [REG_W-1:0] step_word(input logic [REG_W-1:0] first,
                                                   input logic [REG_W-1:0] step, input int i);
        return first + step * 16'(i);
    endfunction

    function automatic void build_table();
        table_test = 4'd1;                                          // reset values
        add_row(OP_RD, REG_VRAM_ADDR, '0, 16'h0000);
        add_row(OP_RD, REG_VRAM_INCR, '0, 16'h0000);
        add_row(OP_RD, REG_FILL_COUNT, '0, 16'h0000);
        table_test = 4'd2;                                          // full word readback
        add_row(OP_WR, REG_VRAM_ADDR, 16'hA35C, '0);
        add_row(OP_RD, REG_VRAM_ADDR, '0, 16'hA35C);
        add_row(OP_WR, REG_VRAM_INCR, 16'h0102, '0);
        add_row(OP_RD, REG_VRAM_INCR, '0, 16'h0102);
        table_test = 4'd3;                                          // stray even byte
        add_row(OP_WR_EVEN, REG_FILL_DATA, 16'h7700, '0);
        add_row(OP_WR_ODD, REG_VRAM_ADDR, 16'h00C4, '0);
        add_row(OP_RD, REG_VRAM_ADDR, '0, 16'h00C4);                // high half dropped
        add_row(OP_RD, REG_FILL_DATA, '0, 16'h0000);                // never completed
        table_test = 4'd4;                                          // stepped data port
        add_row(OP_WR, REG_VRAM_INCR, 16'd3, '0);
        add_row(OP_WR, REG_VRAM_ADDR, 16'h0040, '0);
        for (int i = 0; i < 6; i++) begin
            add_row(OP_WR, REG_VRAM_DATA, step_word(16'h1234, 16'h1111, i), '0);
        end
        add_row(OP_WR, REG_VRAM_ADDR, 16'h0040, '0);                // rewind, prefetch
        for (int i = 0; i < 6; i++) begin
            add_row(OP_RD, REG_VRAM_DATA, '0, step_word(16'h1234, 16'h1111, i));
        end
        add_row(OP_RD, REG_VRAM_ADDR, '0, 16'h0040 + 16'd18);       // six steps of 3
        table_test = 4'd5;                                          // plain fill
        add_row(OP_WR, REG_VRAM_INCR, 16'd1, '0);
        add_row(OP_WR, REG_VRAM_ADDR, FILL1_BASE + 16'(FILL1_LEN), '0);
        add_row(OP_WR, REG_VRAM_DATA, 16'h5A5A, '0);                // marker past the range
        add_row(OP_WR, REG_FILL_ADDR, FILL1_BASE, '0);
        add_row(OP_WR, REG_FILL_DATA, 16'hBEEF, '0);
        add_row(OP_WR, REG_FILL_COUNT, 16'(FILL1_LEN), '0);
        add_row(OP_POLL, REG_FILL_COUNT, '0, 16'h0000);
        add_row(OP_WR, REG_VRAM_ADDR, FILL1_BASE, '0);
        for (int i = 0; i < FILL1_LEN; i++) begin
            add_row(OP_RD, REG_VRAM_DATA, '0, 16'hBEEF);
        end
        add_row(OP_RD, REG_VRAM_DATA, '0, 16'h5A5A);
        table_test = 4'd6;                                          // host writes during fill
        add_row(OP_WR, REG_FILL_ADDR, FILL2_BASE, '0);
        add_row(OP_WR, REG_FILL_DATA, 16'h0F0F, '0);
        add_row(OP_WR, REG_FILL_COUNT, 16'(FILL2_LEN), '0);
        add_row(OP_WR, REG_VRAM_ADDR, HOST_BASE, '0);
        for (int i = 0; i < 8; i++) begin
            add_row(OP_WR, REG_VRAM_DATA, step_word(16'hC000, 16'h0101, i), '0);
        end
        add_row(OP_POLL, REG_FILL_COUNT, '0, 16'h0000);
        add_row(OP_WR, REG_VRAM_ADDR, HOST_BASE, '0);
        for (int i = 0; i < 8; i++) begin
            add_row(OP_RD, REG_VRAM_DATA, '0, step_word(16'hC000, 16'h0101, i));
        end
        add_row(OP_WR, REG_VRAM_ADDR, FILL2_BASE, '0);
        for (int i = 0; i < FILL2_LEN; i++) begin
            add_row(OP_RD, REG_VRAM_DATA, '0, 16'h0F0F);
        end
        timeout_limit = rows.size() * 32 + FILL1_LEN + FILL2_LEN + 200;
    endfunction

    // one host byte: cs low 4 clks, then high 4 clks
    task automatic byte_cycle(input logic read, input logic [3:0] reg_num, input logic odd,
                              input logic [7:0] wr_byte, input logic cmp,
                              input logic [7:0] exp_byte);
        @(posedge clk);
        bus_cs_n    <= CS_ENABLED;
        bus_rd_nwr  <= read ? RNW_READ : !RNW_READ;
        bus_reg_num <= reg_num;
        bus_bytesel <= odd;
        bus_data_in <= wr_byte;
        repeat (3) @(posedge clk);
        sample_req  <= 1'b1;                    // checker samples on the next negedge
        sample_cmp  <= cmp;
        sample_exp  <= exp_byte;
        @(posedge clk);
        sample_req  <= 1'b0;
        bus_cs_n    <= !CS_ENABLED;
        repeat (3) @(posedge clk);
    endtask

    task automatic report_fault();
        fault <= 1'b1;
        @(posedge clk);
        fault <= 1'b0;
    endtask

    task automatic end_test(input logic [3:0] num);
        test_num  <= num;
        test_done <= 1'b1;
        @(posedge clk);
        test_done <= 1'b0;
    endtask

    task automatic apply_row(input row_t r);
        logic [REG_W-1:0] got;
        int               polls;
        case (r.op)
            OP_WR: begin
                byte_cycle(1'b0, r.reg_num, 1'b0, r.word[15:8], 1'b0, 8'h00);
                byte_cycle(1'b0, r.reg_num, 1'b1, r.word[7:0], 1'b0, 8'h00);
            end
            OP_WR_EVEN: byte_cycle(1'b0, r.reg_num, 1'b0, r.word[15:8], 1'b0, 8'h00);
            OP_WR_ODD:  byte_cycle(1'b0, r.reg_num, 1'b1, r.word[7:0], 1'b0, 8'h00);
            OP_RD: begin
                byte_cycle(1'b1, r.reg_num, 1'b0, 8'h00, 1'b1, r.exp_word[15:8]);
                byte_cycle(1'b1, r.reg_num, 1'b1, 8'h00, 1'b1, r.exp_word[7:0]);
            end
            OP_POLL: begin
                polls = 0;
                do begin
                    byte_cycle(1'b1, r.reg_num, 1'b0, 8'h00, 1'b0, 8'h00);
                    got[15:8] = sampled;
                    byte_cycle(1'b1, r.reg_num, 1'b1, 8'h00, 1'b0, 8'h00);
                    got[7:0] = sampled;
                    polls++;
                end while (got != r.exp_word && polls < POLL_LIMIT);
                if (got != r.exp_word) begin
                    $display("fill never finished: FILL_COUNT still %0d after %0d polls",
                             got, polls);
                    report_fault();
                end
            end
            default: ;
        endcase
    endtask

    initial begin
        logic [3:0] cur_test;
        reset_i     = 1'b1;
        bus_cs_n    = !CS_ENABLED;              // bus idle
        bus_rd_nwr  = RNW_READ;
        bus_reg_num = 4'h0;
        bus_bytesel = 1'b0;
        bus_data_in = 8'h00;
        sample_req  = 1'b0;
        sample_cmp  = 1'b0;
        sample_exp  = 8'h00;
        fault       = 1'b0;
        test_done   = 1'b0;
        test_num    = 4'd0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
        cur_test = rows[0].test;
        foreach (rows[i]) begin
            if (rows[i].test != cur_test) begin
                end_test(cur_test);
                cur_test = rows[i].test;
            end
            test_num <= rows[i].test;
            apply_row(rows[i]);
        end
        end_test(cur_test);
        repeat (2) @(posedge clk);              // let the checker counts settle
        $display("summary: %0d byte checks, %0d errors", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/vreg_pkg.sv
hw/vram.sv
hw/vram_arbiter.sv
hw/vram_fill.sv
hw/vram_regs.sv
hw/bus_interface.sv
hw/vreg_top.sv
test/vreg_checker.sv
test/vreg_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vreg_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx 'TEST PASSED' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
